// ==== Bender.yml ====
package:
  name: ooo_channel

sources:
  - files:
      - src/ooo_channel_pkg.sv
      - src/request_stager.sv
      - src/wait_stations.sv
      - src/line_unroller.sv
      - src/response_queue.sv
      - src/ooo_channel.sv
  - target: test
    files:
      - test/ooo_channel_assertions.sv
      - test/ooo_channel_checker.sv
      - test/ooo_channel_tb.sv

// ==== filelist.f ====
src/ooo_channel_pkg.sv
src/request_stager.sv
src/wait_stations.sv
src/line_unroller.sv
src/response_queue.sv
src/ooo_channel.sv
test/ooo_channel_assertions.sv
test/ooo_channel_checker.sv
test/ooo_channel_tb.sv

// ==== src/line_unroller.sv ====
// takes one ready slot and emits its cache lines one per cycle with response headers
`timescale 1ns/1ps

module line_unroller (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          ready_i,
   input  ooo_channel_pkg::req_entry_t   ready_entry_i,
   input  logic                          almfull_i,
   output logic                          take_o,
   output logic                          line_push_o,
   output ooo_channel_pkg::resp_entry_t  line_o
);

   ooo_channel_pkg::req_entry_t cur;
   logic                        busy;
   logic [1:0]                  line_cnt;

   // one burst in flight at most
   assign take_o      = !busy && ready_i && !almfull_i;
   assign line_push_o = busy;

   // line k of the latched request
   always_comb begin
      line_o.txhdr       = cur.hdr;
      line_o.txhdr.addr  = cur.hdr.addr + ooo_channel_pkg::ADDR_W'(line_cnt);
      line_o.rxhdr.resptype = (cur.hdr.reqtype == ooo_channel_pkg::REQ_RDLINE) ?
                              ooo_channel_pkg::RESP_RD : ooo_channel_pkg::RESP_WR;
      line_o.rxhdr.vc    = cur.hdr.vc;
      line_o.rxhdr.clnum = line_cnt;
      line_o.rxhdr.mdata = cur.hdr.mdata;
      line_o.data        = cur.data;
      line_o.tid         = cur.tid;
   end

   // latched request
   always_ff @(posedge clk) begin
      if (take_o) begin
         cur <= ready_entry_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         busy     <= 1'b0;
         line_cnt <= '0;
      end else if (take_o) begin
         busy     <= 1'b1;
         line_cnt <= '0;
      end else if (busy) begin
         line_cnt <= line_cnt + 1'b1;
         // len is last line index
         if (line_cnt == cur.hdr.len) begin
            busy <= 1'b0;
         end
      end
   end

endmodule

// ==== src/ooo_channel.sv ====
// top level of the out-of-order latency channel wiring stager, stations, unroller and output queue
`timescale 1ns/1ps

module ooo_channel (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                write_en_i,
   input  ooo_channel_pkg::tx_hdr_t            hdr_i,
   input  logic [ooo_channel_pkg::DATA_W-1:0]  data_i,
   output logic                                full_o,
   output logic                                empty_o,
   input  logic                                read_en_i,
   output logic                                valid_o,
   output ooo_channel_pkg::tx_hdr_t            txhdr_o,
   output ooo_channel_pkg::rx_hdr_t            rxhdr_o,
   output logic [ooo_channel_pkg::DATA_W-1:0]  data_o,
   output logic [ooo_channel_pkg::TID_W-1:0]   tid_o
);

   // stager to stations
   logic                         slot_free;
   logic                         push;
   ooo_channel_pkg::req_entry_t  push_entry;
   // stations to unroller
   logic                         ready;
   logic                         take;
   ooo_channel_pkg::req_entry_t  ready_entry;
   // unroller to output queue
   logic                         line_push;
   logic                         almfull;
   ooo_channel_pkg::resp_entry_t line;

   request_stager u_stager (
      .clk         (clk),
      .rst         (rst),
      .write_en_i  (write_en_i),
      .hdr_i       (hdr_i),
      .data_i      (data_i),
      .slot_free_i (slot_free),
      .full_o      (full_o),
      .push_o      (push),
      .entry_o     (push_entry)
   );

   wait_stations u_stations (
      .clk           (clk),
      .rst           (rst),
      .push_i        (push),
      .entry_i       (push_entry),
      .take_i        (take),
      .slot_free_o   (slot_free),
      .ready_o       (ready),
      .ready_entry_o (ready_entry)
   );

   line_unroller u_unroller (
      .clk           (clk),
      .rst           (rst),
      .ready_i       (ready),
      .ready_entry_i (ready_entry),
      .almfull_i     (almfull),
      .take_o        (take),
      .line_push_o   (line_push),
      .line_o        (line)
   );

   response_queue u_outq (
      .clk         (clk),
      .rst         (rst),
      .line_push_i (line_push),
      .line_i      (line),
      .read_en_i   (read_en_i),
      .almfull_o   (almfull),
      .empty_o     (empty_o),
      .valid_o     (valid_o),
      .txhdr_o     (txhdr_o),
      .rxhdr_o     (rxhdr_o),
      .data_o      (data_o),
      .tid_o       (tid_o)
   );

endmodule

// ==== src/ooo_channel_pkg.sv ====
// shared widths, depths, thresholds, enums and header/entry structs for the latency channel
package ooo_channel_pkg;

   //////////////////////////////
   // widths and depths
   //////////////////////////////
   localparam int DATA_W             = 64;
   localparam int ADDR_W             = 42;
   localparam int MDATA_W            = 16;
   localparam int TID_W              = 32;
   localparam int IN_DEPTH           = 32;
   localparam int OUT_DEPTH          = 32;
   localparam int IN_PTR_W           = $clog2(IN_DEPTH);
   localparam int OUT_PTR_W          = $clog2(OUT_DEPTH);

   // input fill above this raises full
   localparam int FULL_THRESH        = 24;
   // leaves room for one four-line burst
   localparam int OUT_ALMFULL_THRESH = 27;

   // wait stations and delay source
   localparam int NUM_STATIONS       = 16;
   localparam int SLOT_W             = $clog2(NUM_STATIONS);
   localparam int CTR_W              = 8;
   localparam int DELAY_MIN          = 15;
   localparam int DELAY_MASK         = 31;
   localparam logic [15:0] LFSR_SEED = 16'hACE1;

   //////////////////////////////
   // encodings
   //////////////////////////////
   typedef enum logic {REQ_RDLINE, REQ_WRLINE} req_type_e;
   typedef enum logic {RESP_RD, RESP_WR} resp_type_e;
   typedef enum logic [1:0] {VC_VA, VC_VL0, VC_VH0, VC_VH1} vc_e;
   typedef enum logic [1:0] {ST_IDLE, ST_COUNTDOWN, ST_READY, ST_POPPED} station_state_e;

   //////////////////////////////
   // headers and entries
   //////////////////////////////
   // request header with len 0/1/3 meaning 1/2/4 lines
   typedef struct packed {
      req_type_e           reqtype;
      vc_e                 vc;
      logic [1:0]          len;
      logic [ADDR_W-1:0]   addr;
      logic [MDATA_W-1:0]  mdata;
   } tx_hdr_t;

   // response header with clnum as the line index in the burst
   typedef struct packed {
      resp_type_e          resptype;
      vc_e                 vc;
      logic [1:0]          clnum;
      logic [MDATA_W-1:0]  mdata;
   } rx_hdr_t;

   typedef struct packed {
      tx_hdr_t             hdr;
      logic [DATA_W-1:0]   data;
      logic [TID_W-1:0]    tid;
   } req_entry_t;

   typedef struct packed {
      tx_hdr_t             txhdr;
      rx_hdr_t             rxhdr;
      logic [DATA_W-1:0]   data;
      logic [TID_W-1:0]    tid;
   } resp_entry_t;

endpackage

// ==== src/request_stager.sv ====
// input queue with tid counter, full flag and round-robin resolution of auto channel requests
`timescale 1ns/1ps

module request_stager (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                write_en_i,
   input  ooo_channel_pkg::tx_hdr_t            hdr_i,
   input  logic [ooo_channel_pkg::DATA_W-1:0]  data_i,
   input  logic                                slot_free_i,
   output logic                                full_o,
   output logic                                push_o,
   output ooo_channel_pkg::req_entry_t         entry_o
);

   ooo_channel_pkg::req_entry_t in_mem [ooo_channel_pkg::IN_DEPTH];

   logic [ooo_channel_pkg::IN_PTR_W-1:0] wr_ptr;
   logic [ooo_channel_pkg::IN_PTR_W-1:0] rd_ptr;
   logic [ooo_channel_pkg::IN_PTR_W:0]   count;
   logic [ooo_channel_pkg::TID_W-1:0]    tid;
   ooo_channel_pkg::vc_e                 rr_vc;
   ooo_channel_pkg::vc_e                 rr_next;
   ooo_channel_pkg::req_entry_t          head;
   logic                                 wr_acc;
   logic                                 do_pop;

   // vl0 -> vh0 -> vh1 -> vl0
   function automatic ooo_channel_pkg::vc_e rr_step(input ooo_channel_pkg::vc_e cur);
      case (cur)
         ooo_channel_pkg::VC_VL0: return ooo_channel_pkg::VC_VH0;
         ooo_channel_pkg::VC_VH0: return ooo_channel_pkg::VC_VH1;
         default:                 return ooo_channel_pkg::VC_VL0;
      endcase
   endfunction

   // writes past the threshold still land until the queue is truly full
   assign wr_acc  = write_en_i
                    && (count != (ooo_channel_pkg::IN_PTR_W+1)'(ooo_channel_pkg::IN_DEPTH));
   // head leaves only when a station can take it
   assign do_pop  = (count != '0) && slot_free_i;
   assign rr_next = rr_step(rr_vc);

   // head with auto channel resolved
   always_comb begin
      head = in_mem[rd_ptr];
      if (head.hdr.vc == ooo_channel_pkg::VC_VA) begin
         head.hdr.vc = rr_next;
      end
   end

   // queue storage and staged head entry
   always_ff @(posedge clk) begin
      if (wr_acc) begin
         in_mem[wr_ptr] <= '{hdr: hdr_i, data: data_i, tid: tid};
      end
      if (do_pop) begin
         entry_o <= head;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         tid    <= '0;
         rr_vc  <= ooo_channel_pkg::VC_VL0;
         push_o <= 1'b0;
         full_o <= 1'b1;
      end else begin
         // full lags the count by one cycle
         full_o <= (count > (ooo_channel_pkg::IN_PTR_W+1)'(ooo_channel_pkg::FULL_THRESH));
         push_o <= do_pop;
         count  <= count + (ooo_channel_pkg::IN_PTR_W+1)'(wr_acc)
                         - (ooo_channel_pkg::IN_PTR_W+1)'(do_pop);
         if (wr_acc) begin
            wr_ptr <= wr_ptr + 1'b1;
            tid    <= tid + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
            // only auto requests move the arbiter
            if (in_mem[rd_ptr].hdr.vc == ooo_channel_pkg::VC_VA) begin
               rr_vc <= rr_next;
            end
         end
      end
   end

endmodule

// ==== src/response_queue.sv ====
// output queue with empty and almost-full flags and registered read pop
`timescale 1ns/1ps

module response_queue (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                line_push_i,
   input  ooo_channel_pkg::resp_entry_t        line_i,
   input  logic                                read_en_i,
   output logic                                almfull_o,
   output logic                                empty_o,
   output logic                                valid_o,
   output ooo_channel_pkg::tx_hdr_t            txhdr_o,
   output ooo_channel_pkg::rx_hdr_t            rxhdr_o,
   output logic [ooo_channel_pkg::DATA_W-1:0]  data_o,
   output logic [ooo_channel_pkg::TID_W-1:0]   tid_o
);

   localparam int PW = ooo_channel_pkg::OUT_PTR_W;

   ooo_channel_pkg::resp_entry_t out_mem [ooo_channel_pkg::OUT_DEPTH];

   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [PW:0]   count;
   logic          do_pop;

   assign empty_o   = (count == '0);
   assign almfull_o = (count >= (PW+1)'(ooo_channel_pkg::OUT_ALMFULL_THRESH));
   // read on empty is dropped
   assign do_pop    = read_en_i && !empty_o;

   always_ff @(posedge clk) begin
      if (line_push_i) begin
         out_mem[wr_ptr] <= line_i;
      end
      if (do_pop) begin
         {txhdr_o, rxhdr_o, data_o, tid_o} <= out_mem[rd_ptr];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         valid_o <= 1'b0;
      end else begin
         // one-cycle valid per pop
         valid_o <= do_pop;
         count   <= count + (PW+1)'(line_push_i) - (PW+1)'(do_pop);
         if (line_push_i) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

endmodule

// ==== src/wait_stations.sv ====
// wait station slots with countdown FSMs, LFSR delay source and rotating free/ready slot search
`timescale 1ns/1ps

module wait_stations (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         push_i,
   input  ooo_channel_pkg::req_entry_t  entry_i,
   input  logic                         take_i,
   output logic                         slot_free_o,
   output logic                         ready_o,
   output ooo_channel_pkg::req_entry_t  ready_entry_o
);

   localparam int N  = ooo_channel_pkg::NUM_STATIONS;
   localparam int SW = ooo_channel_pkg::SLOT_W;

   ooo_channel_pkg::station_state_e         state [N];
   logic [ooo_channel_pkg::CTR_W-1:0]       ctr [N];
   ooo_channel_pkg::req_entry_t             slot_entry [N];

   logic [15:0]                             lfsr;
   logic [ooo_channel_pkg::CTR_W-1:0]       delay;
   logic [SW-1:0]                           push_ptr;
   logic [SW-1:0]                           pop_ptr;
   logic [N-1:0]                            idle_vec;
   logic [N-1:0]                            ready_vec;
   logic [N-1:0]                            load_vec;
   logic [SW:0]                             push_sel;
   logic [SW:0]                             pop_sel;

   // first set bit at or after start with msb flagging a hit
   function automatic logic [SW:0] find_from(input logic [N-1:0] vec,
                                             input logic [SW-1:0] start);
      logic          found;
      logic [SW-1:0] idx;
      logic [SW-1:0] pick;
      found = 1'b0;
      pick  = start;
      for (int i = 0; i < N; i++) begin
         idx = start + SW'(i);
         if (!found && vec[idx]) begin
            found = 1'b1;
            pick  = idx;
         end
      end
      return {found, pick};
   endfunction

   always_comb begin
      for (int s = 0; s < N; s++) begin
         idle_vec[s]  = (state[s] == ooo_channel_pkg::ST_IDLE);
         ready_vec[s] = (state[s] == ooo_channel_pkg::ST_READY);
      end
   end

   assign push_sel = find_from(idle_vec, push_ptr);
   assign pop_sel  = find_from(ready_vec, pop_ptr);
   assign load_vec = (push_i && push_sel[SW]) ? (N'(1) << push_sel[SW-1:0]) : '0;

   // a slot being filled this cycle no longer counts as free
   assign slot_free_o   = |(idle_vec & ~load_vec);
   assign ready_o       = pop_sel[SW];
   assign ready_entry_o = slot_entry[pop_sel[SW-1:0]];

   // delay range DELAY_MIN .. DELAY_MIN+DELAY_MASK
   assign delay = ooo_channel_pkg::CTR_W'(ooo_channel_pkg::DELAY_MIN)
                + (lfsr[ooo_channel_pkg::CTR_W-1:0]
                   & ooo_channel_pkg::CTR_W'(ooo_channel_pkg::DELAY_MASK));

   //////////////////////////////
   // payload and counters
   //////////////////////////////
   always_ff @(posedge clk) begin
      for (int s = 0; s < N; s++) begin
         if (load_vec[s]) begin
            slot_entry[s] <= entry_i;
            ctr[s]        <= delay;
         end else if (state[s] == ooo_channel_pkg::ST_COUNTDOWN && ctr[s] != '0) begin
            ctr[s] <= ctr[s] - 1'b1;
         end
      end
   end

   //////////////////////////////
   // slot FSMs and pointers
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         lfsr     <= ooo_channel_pkg::LFSR_SEED;
         push_ptr <= '0;
         pop_ptr  <= '0;
         for (int s = 0; s < N; s++) begin
            state[s] <= ooo_channel_pkg::ST_IDLE;
         end
      end else begin
         // x^16 + x^14 + x^13 + x^11 stepping every cycle
         lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
         if (push_i) begin
            push_ptr <= push_sel[SW-1:0] + 1'b1;
         end
         if (take_i) begin
            pop_ptr <= pop_sel[SW-1:0] + 1'b1;
         end
         for (int s = 0; s < N; s++) begin
            case (state[s])
               ooo_channel_pkg::ST_IDLE: begin
                  if (load_vec[s]) begin
                     state[s] <= ooo_channel_pkg::ST_COUNTDOWN;
                  end
               end
               ooo_channel_pkg::ST_COUNTDOWN: begin
                  // ready after delay+1 cycles
                  if (ctr[s] == '0) begin
                     state[s] <= ooo_channel_pkg::ST_READY;
                  end
               end
               ooo_channel_pkg::ST_READY: begin
                  if (take_i && pop_sel[SW-1:0] == SW'(s)) begin
                     state[s] <= ooo_channel_pkg::ST_POPPED;
                  end
               end
               default: begin
                  state[s] <= ooo_channel_pkg::ST_IDLE;
               end
            endcase
         end
      end
   end

endmodule

// ==== test/ooo_channel_assertions.sv ====
// concurrent assertions on the channel top level and their bind
`timescale 1ns/1ps

module ooo_channel_assertions (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      write_en_i,
   input  ooo_channel_pkg::tx_hdr_t  hdr_i,
   input  logic                      read_en_i,
   input  logic                      valid_i,
   input  logic                      full_i
);

   // two valid cycles in a row need two reads in a row
   valid_pulse_chk: assert property (@(posedge clk) disable iff (rst)
      (valid_i && $past(valid_i)) |-> ($past(read_en_i) && $past(read_en_i, 2)))
      else $error("valid_o held high without back-to-back reads");

   // length code 2 is not a legal request
   len_legal_chk: assert property (@(posedge clk) disable iff (rst)
      write_en_i |-> (hdr_i.len != 2'd2))
      else $error("write carried header length code 2");

   // covers reset and the first cycle after it
   reset_full_chk: assert property (@(posedge clk)
      $past(rst) |-> full_i)
      else $error("full_o low while reset was applied");

endmodule

bind ooo_channel ooo_channel_assertions u_assertions (
   .clk        (clk),
   .rst        (rst),
   .write_en_i (write_en_i),
   .hdr_i      (hdr_i),
   .read_en_i  (read_en_i),
   .valid_i    (valid_o),
   .full_i     (full_o)
);

// ==== test/ooo_channel_checker.sv ====
// scoreboard predicting every response from snooped writes and comparing it at the outputs
`timescale 1ns/1ps

module ooo_channel_checker (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                write_en_i,
   input  ooo_channel_pkg::tx_hdr_t            hdr_i,
   input  logic [ooo_channel_pkg::DATA_W-1:0]  data_i,
   input  logic                                full_i,
   input  logic                                empty_i,
   input  logic                                read_en_i,
   input  logic                                valid_i,
   input  ooo_channel_pkg::tx_hdr_t            txhdr_i,
   input  ooo_channel_pkg::rx_hdr_t            rxhdr_i,
   input  logic [ooo_channel_pkg::DATA_W-1:0]  rdata_i,
   input  logic [ooo_channel_pkg::TID_W-1:0]   tid_i,
   output int                                  errors_o,
   output int                                  lines_seen_o,
   output logic                                saw_full_o
);

   localparam int MAX_REQ = 128;

   // expected request per tid with vc already resolved
   ooo_channel_pkg::tx_hdr_t           exp_hdr [MAX_REQ];
   logic [ooo_channel_pkg::DATA_W-1:0] exp_data [MAX_REQ];
   int                                 wr_cycle [MAX_REQ];
   int                                 next_line [MAX_REQ];

   int                   num_writes = 0;
   int                   errors = 0;
   int                   lines_seen = 0;
   int                   cycle = 0;
   // tid of a burst still in progress
   // -1 when no burst is open
   int                   open_tid = -1;
   logic                 exp_valid = 1'b0;
   logic                 rst_d = 1'b1;
   logic                 saw_full = 1'b0;
   ooo_channel_pkg::vc_e rr_vc = ooo_channel_pkg::VC_VL0;

   assign errors_o     = errors;
   assign lines_seen_o = lines_seen;
   assign saw_full_o   = saw_full;

   task automatic compare_field(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
      end
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("error at %0t: %s", $time, what);
   endtask

   // auto requests take vh0, vh1, vl0 in write order
   task automatic record_write();
      ooo_channel_pkg::tx_hdr_t h;
      h = hdr_i;
      if (h.vc == ooo_channel_pkg::VC_VA) begin
         case (rr_vc)
            ooo_channel_pkg::VC_VL0: rr_vc = ooo_channel_pkg::VC_VH0;
            ooo_channel_pkg::VC_VH0: rr_vc = ooo_channel_pkg::VC_VH1;
            default:                 rr_vc = ooo_channel_pkg::VC_VL0;
         endcase
         h.vc = rr_vc;
      end
      if (num_writes >= MAX_REQ) begin
         report_failure("more writes than the scoreboard can track");
      end else begin
         exp_hdr[num_writes]   = h;
         exp_data[num_writes]  = data_i;
         wr_cycle[num_writes]  = cycle;
         next_line[num_writes] = 0;
         num_writes++;
      end
   endtask

   task automatic check_response();
      ooo_channel_pkg::tx_hdr_t   e;
      ooo_channel_pkg::resp_type_e rt;
      int                          t;
      int                          k;
      if (tid_i >= ooo_channel_pkg::TID_W'(num_writes)) begin
         report_failure("response carries a tid that was never written");
         return;
      end
      t = int'(tid_i);
      e = exp_hdr[t];
      k = next_line[t];
      if (k > int'(e.len)) begin
         report_failure("response repeated beyond the lines of its request");
         return;
      end
      // lines of one burst stay together
      if (open_tid >= 0) begin
         compare_field("tid_o", tid_i, open_tid);
      end
      rt = (e.reqtype == ooo_channel_pkg::REQ_RDLINE) ?
           ooo_channel_pkg::RESP_RD : ooo_channel_pkg::RESP_WR;
      compare_field("txhdr_o.reqtype", txhdr_i.reqtype, e.reqtype);
      compare_field("txhdr_o.vc", txhdr_i.vc, e.vc);
      compare_field("txhdr_o.len", txhdr_i.len, e.len);
      compare_field("txhdr_o.addr", txhdr_i.addr, e.addr + ooo_channel_pkg::ADDR_W'(k));
      compare_field("txhdr_o.mdata", txhdr_i.mdata, e.mdata);
      compare_field("rxhdr_o.resptype", rxhdr_i.resptype, rt);
      compare_field("rxhdr_o.vc", rxhdr_i.vc, e.vc);
      compare_field("rxhdr_o.clnum", rxhdr_i.clnum, k);
      compare_field("rxhdr_o.mdata", rxhdr_i.mdata, e.mdata);
      compare_field("data_o", rdata_i, exp_data[t]);
      if (cycle - wr_cycle[t] < ooo_channel_pkg::DELAY_MIN) begin
         report_failure("response came back sooner than the minimum delay");
      end
      next_line[t] = k + 1;
      lines_seen++;
      open_tid = (k == int'(e.len)) ? -1 : t;
   endtask

   always @(posedge clk) begin
      cycle++;
      if (rst) begin
         exp_valid = 1'b0;
         open_tid  = -1;
      end else begin
         if (rst_d && !full_i) begin
            report_failure("full_o low on the first cycle after reset");
         end
         if (rst_d && !empty_i) begin
            report_failure("empty_o low on the first cycle after reset");
         end
         // valid follows a read of a non-empty queue by one cycle
         compare_field("valid_o", valid_i, exp_valid);
         if (valid_i) begin
            check_response();
         end
         if (write_en_i) begin
            record_write();
         end
         if (full_i && num_writes > 0) begin
            saw_full = 1'b1;
         end
         exp_valid = read_en_i && !empty_i;
      end
      rst_d = rst;
   end

endmodule

// ==== test/ooo_channel_tb.sv ====
// testbench top with clock, reset, request table, write and read processes, watchdog and summary
`timescale 1ns/1ps

module ooo_channel_tb;

   localparam int TABLE_LEN    = 24;
   // enough requests to back the channel up to full
   localparam int PASSES       = 3;
   localparam int NUM_REQ      = TABLE_LEN * PASSES;
   localparam int RESET_CYCLES = 4;
   localparam int STALL_CYCLES = 300;
   // worst delay, four lines and queueing slack per request
   localparam int WATCHDOG_CYCLES = NUM_REQ * (46 + 4 + 20) + STALL_CYCLES + RESET_CYCLES;

   typedef struct packed {
      logic                                reqtype;
      logic [1:0]                          vc;
      logic [1:0]                          len;
      logic [ooo_channel_pkg::ADDR_W-1:0]  addr;
      logic [ooo_channel_pkg::MDATA_W-1:0] mdata;
      logic [ooo_channel_pkg::DATA_W-1:0]  data;
      logic [2:0]                          lines;
   } stim_row_t;

   logic                                clk;
   logic                                rst;
   logic                                write_en_i;
   ooo_channel_pkg::tx_hdr_t            hdr_i;
   logic [ooo_channel_pkg::DATA_W-1:0]  data_i;
   logic                                full_o;
   logic                                empty_o;
   logic                                read_en_i;
   logic                                valid_o;
   ooo_channel_pkg::tx_hdr_t            txhdr_o;
   ooo_channel_pkg::rx_hdr_t            rxhdr_o;
   logic [ooo_channel_pkg::DATA_W-1:0]  data_o;
   logic [ooo_channel_pkg::TID_W-1:0]   tid_o;

   int          chk_errors;
   int          lines_seen;
   logic        saw_full;
   int          tb_errors = 0;
   int          total_lines = 0;
   int          table_fill = 0;
   logic        reads_done = 1'b0;
   logic [31:0] lcg_state = 32'd86336;
   stim_row_t   stim_table [TABLE_LEN];

   ooo_channel u_dut (.*);

   ooo_channel_checker u_checker (
      .clk          (clk),
      .rst          (rst),
      .write_en_i   (write_en_i),
      .hdr_i        (hdr_i),
      .data_i       (data_i),
      .full_i       (full_o),
      .empty_i      (empty_o),
      .read_en_i    (read_en_i),
      .valid_i      (valid_o),
      .txhdr_i      (txhdr_o),
      .rxhdr_i      (rxhdr_o),
      .rdata_i      (data_o),
      .tid_i        (tid_o),
      .errors_o     (chk_errors),
      .lines_seen_o (lines_seen),
      .saw_full_o   (saw_full)
   );

   function automatic logic [15:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[31:16];
   endfunction

   task automatic add_row(input logic rt, input logic [1:0] vc, input logic [1:0] len,
                          input logic [41:0] addr, input logic [15:0] mdata,
                          input logic [63:0] data, input logic [2:0] lines);
      stim_table[table_fill] = '{rt, vc, len, addr, mdata, data, lines};
      table_fill++;
   endtask

   // holds off while full and sends one write strobe per request
   task automatic send_request(input stim_row_t row, input int pass);
      while (full_o) begin
         @(posedge clk);
         #1;
      end
      write_en_i        = 1'b1;
      hdr_i.reqtype     = ooo_channel_pkg::req_type_e'(row.reqtype);
      hdr_i.vc          = ooo_channel_pkg::vc_e'(row.vc);
      hdr_i.len         = row.len;
      hdr_i.addr        = row.addr + ooo_channel_pkg::ADDR_W'(pass * 'h1000);
      hdr_i.mdata       = row.mdata + ooo_channel_pkg::MDATA_W'(pass);
      data_i            = row.data + ooo_channel_pkg::DATA_W'(pass);
      @(posedge clk);
      #1;
      write_en_i = 1'b0;
   endtask

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   //////////////////////////////
   // request table and writes
   //////////////////////////////
   initial begin
      rst        = 1'b1;
      write_en_i = 1'b0;
      hdr_i      = '0;
      data_i     = '0;
      // columns rt vc len addr mdata data lines
      // vc 0 is auto
      add_row(0, 0, 0, 42'h0000100, 16'h1001, 64'h0123_4567_89ab_cdef, 1);
      add_row(1, 0, 1, 42'h0000200, 16'h1002, 64'hfeed_0000_0000_0001, 2);
      add_row(0, 1, 3, 42'h0000300, 16'h1003, 64'h1111_2222_3333_4444, 4);
      add_row(0, 0, 3, 42'h0000400, 16'h1004, 64'hdead_beef_0000_0004, 4);
      add_row(1, 2, 0, 42'h0000500, 16'h1005, 64'h5555_aaaa_5555_aaaa, 1);
      add_row(0, 3, 1, 42'h0000600, 16'h1006, 64'h0000_0000_0000_0006, 2);
      add_row(1, 0, 0, 42'h0000700, 16'h1007, 64'hcafe_f00d_0000_0007, 1);
      add_row(0, 0, 1, 42'h0000800, 16'h1008, 64'h8888_7777_6666_5555, 2);
      add_row(1, 1, 0, 42'h0000900, 16'h1009, 64'h0f0f_0f0f_0f0f_0f0f, 1);
      add_row(0, 2, 3, 42'h0000a00, 16'h100a, 64'ha5a5_a5a5_0000_000a, 4);
      add_row(1, 0, 3, 42'h0000b00, 16'h100b, 64'h0000_ffff_0000_ffff, 4);
      add_row(0, 3, 0, 42'h0000c00, 16'h100c, 64'h1234_0000_0000_000c, 1);
      add_row(0, 0, 0, 42'h0000d00, 16'h100d, 64'h0000_0000_dddd_dddd, 1);
      add_row(1, 1, 1, 42'h0000e00, 16'h100e, 64'heeee_0000_eeee_0000, 2);
      add_row(0, 0, 1, 42'h0000f00, 16'h100f, 64'h0000_0000_0000_000f, 2);
      add_row(1, 3, 3, 42'h0001000, 16'h1010, 64'h1010_1010_1010_1010, 4);
      add_row(0, 2, 0, 42'h0001100, 16'h1011, 64'h7fff_ffff_ffff_ffff, 1);
      add_row(1, 0, 0, 42'h0001200, 16'h1012, 64'h8000_0000_0000_0000, 1);
      add_row(0, 1, 1, 42'h0001300, 16'h1013, 64'h0000_1313_0000_1313, 2);
      add_row(0, 0, 3, 42'h0001400, 16'h1014, 64'h1414_1414_0000_0000, 4);
      add_row(1, 2, 1, 42'h0001500, 16'h1015, 64'h0000_0000_1515_1515, 2);
      add_row(0, 3, 0, 42'h0001600, 16'h1016, 64'h1616_0000_1616_0000, 1);
      add_row(1, 0, 1, 42'h0001700, 16'h1017, 64'hffff_ffff_ffff_ffff, 2);
      add_row(0, 0, 0, 42'h0001800, 16'h1018, 64'h0000_0000_0000_0000, 1);
      for (int i = 0; i < TABLE_LEN; i++) begin
         total_lines += int'(stim_table[i].lines) * PASSES;
      end

      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst = 1'b0;

      for (int p = 0; p < PASSES; p++) begin
         for (int i = 0; i < TABLE_LEN; i++) begin
            send_request(stim_table[i], p);
         end
      end

      // drain until every line is back
      while (lines_seen < total_lines) begin
         @(posedge clk);
      end
      reads_done = 1'b1;
      repeat (4) @(posedge clk);
      #1;
      if (!empty_o) begin
         tb_errors++;
         $display("error: output queue not empty after all responses arrived");
      end
      if (!saw_full) begin
         tb_errors++;
         $display("error: full_o never rose during the read stall");
      end
      $display("summary: %0d checker errors, %0d testbench errors, %0d of %0d responses",
               chk_errors, tb_errors, lines_seen, total_lines);
      if (chk_errors == 0 && tb_errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   //////////////////////////////
   // read strobe
   //////////////////////////////
   initial begin
      read_en_i = 1'b0;
      // long stall backs the channel up
      repeat (RESET_CYCLES + STALL_CYCLES) @(posedge clk);
      while (!reads_done) begin
         #1;
         read_en_i = (lcg_next() % 4) != 0;
         @(posedge clk);
      end
      #1;
      read_en_i = 1'b0;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("error: watchdog expired with %0d of %0d responses", lines_seen, total_lines);
      $display("Test failed");
      $finish;
   end

endmodule
